//--- Bender.yml
package:
  name: mcu_cmd

sources:
  - common/mcu_cmd_pkg.sv
  - rtl/cmd_cfg_regs.sv
  - rtl/addr_pointer.sv
  - rtl/mem_access.sv
  - rtl/spi_readback.sv
  - rtl/mcu_cmd.sv
  - target: test
    files:
      - verif/tb_mcu_cmd.sv

//--- common/mcu_cmd_pkg.sv
`default_nettype none

package mcu_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int data_w   = 8;
  localparam int addr_w   = 24;
  localparam int mapper_w = 3;
  localparam int cnt_w    = 32;
  localparam int vol_w    = 3;

  ////////////////////////////////////////////////////////////
  // opcodes, upper nibble of the command byte
  ////////////////////////////////////////////////////////////

  localparam logic [3:0] op_addr      = 4'h0;
  localparam logic [3:0] op_rom_mask  = 4'h1;
  localparam logic [3:0] op_save_mask = 4'h2;
  localparam logic [3:0] op_mapper    = 4'h3;
  localparam logic [3:0] op_read      = 4'h8;
  localparam logic [3:0] op_write     = 4'h9;

  // full-byte commands
  localparam logic [data_w-1:0] cmd_dac_pause  = 8'hE1;
  localparam logic [data_w-1:0] cmd_dac_resume = 8'hE2;
  localparam logic [data_w-1:0] cmd_dac_props  = 8'hEC;
  localparam logic [data_w-1:0] cmd_features   = 8'hED;
  localparam logic [data_w-1:0] cmd_region     = 8'hEE;
  localparam logic [data_w-1:0] cmd_signature  = 8'hF0;
  localparam logic [data_w-1:0] cmd_echo       = 8'hFF;

  // fixed values
  localparam logic [mapper_w-1:0] mapper_rst = 3'd1;
  localparam logic [data_w-1:0]   signature  = 8'hA5;

  ////////////////////////////////////////////////////////////
  // command byte, nibble view and whole-byte view
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [3:0] op;
    logic [3:0] arg;
  } cmd_fields_t;

  typedef union packed {
    cmd_fields_t       f;
    logic [data_w-1:0] raw;
  } cmd_byte_t;

endpackage

`default_nettype wire

//--- mcu_cmd.f
common/mcu_cmd_pkg.sv
rtl/cmd_cfg_regs.sv
rtl/addr_pointer.sv
rtl/mem_access.sv
rtl/spi_readback.sv
rtl/mcu_cmd.sv
verif/tb_mcu_cmd.sv

//--- rtl/addr_pointer.sv
`timescale 1ns/1ps
`default_nettype none

module addr_pointer (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           param_ready,
  input  mcu_cmd_pkg::cmd_byte_t         cmd_data,
  input  logic [mcu_cmd_pkg::data_w-1:0] param_data,
  input  logic [mcu_cmd_pkg::cnt_w-1:0]  spi_byte_cnt,
  input  logic                           next_addr,
  output logic [mcu_cmd_pkg::addr_w-1:0] addr_out
);
  import mcu_cmd_pkg::*;

  logic [cnt_w-1:0] inc_min;
  logic             is_mem_op;
  logic             inc_en;

  // op bit 0 (byte bit 4) delays the first increment by one byte
  assign inc_min = cnt_w'(cmd_data.f.op[0]) + cnt_w'(1);

  // read or write op, with auto-increment requested in arg bit 3
  assign is_mem_op = (cmd_data.f.op[3:1] == op_read[3:1]);
  assign inc_en    = next_addr && is_mem_op && cmd_data.f.arg[3]
                     && (spi_byte_cnt >= inc_min);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_out <= '0;
    end else if (param_ready && (cmd_data.f.op == op_addr)) begin
      case (spi_byte_cnt)
        // first byte also clears the lower part
        cnt_w'(2): addr_out <= {param_data, {(addr_w-data_w){1'b0}}};
        cnt_w'(3): addr_out[addr_w-data_w-1 -: data_w] <= param_data;
        cnt_w'(4): addr_out[data_w-1:0] <= param_data;
        default: ;
      endcase
    end else if (inc_en) begin
      addr_out <= addr_out + addr_w'(1);
    end
  end

endmodule

`default_nettype wire

//--- rtl/cmd_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_cfg_regs (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             param_ready,
  input  mcu_cmd_pkg::cmd_byte_t           cmd_data,
  input  logic [mcu_cmd_pkg::data_w-1:0]   param_data,
  input  logic [mcu_cmd_pkg::cnt_w-1:0]    spi_byte_cnt,
  output logic [mcu_cmd_pkg::mapper_w-1:0] mcu_mapper,
  output logic [mcu_cmd_pkg::addr_w-1:0]   rom_mask,
  output logic [mcu_cmd_pkg::addr_w-1:0]   saveram_mask,
  output logic [mcu_cmd_pkg::data_w-1:0]   featurebits,
  output logic                             region,
  output logic                             dac_play,
  output logic [mcu_cmd_pkg::vol_w-1:0]    dac_vol_select,
  output logic                             dac_palmode
);
  import mcu_cmd_pkg::*;

  // one byte of a mask per parameter, high byte first
  function automatic logic [addr_w-1:0] mask_load(
    input logic [addr_w-1:0] cur,
    input logic [data_w-1:0] data,
    input logic [cnt_w-1:0]  cnt
  );
    logic [addr_w-1:0] nxt;
    nxt = cur;
    case (cnt)
      cnt_w'(2): nxt[addr_w-1 -: data_w] = data;
      cnt_w'(3): nxt[addr_w-data_w-1 -: data_w] = data;
      cnt_w'(4): nxt[data_w-1:0] = data;
      default: ;
    endcase
    return nxt;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcu_mapper     <= mapper_rst;
      rom_mask       <= '0;
      saveram_mask   <= '0;
      featurebits    <= '0;
      region         <= 1'b0;
      dac_play       <= 1'b0;
      dac_vol_select <= '0;
      dac_palmode    <= 1'b0;
    end else if (param_ready) begin
      case (cmd_data.f.op)
        op_mapper: mcu_mapper <= param_data[mapper_w-1:0];
        op_rom_mask: rom_mask <= mask_load(rom_mask, param_data, spi_byte_cnt);
        op_save_mask: saveram_mask <= mask_load(saveram_mask, param_data, spi_byte_cnt);
        default: begin
          // full-byte commands
          case (cmd_data.raw)
            cmd_dac_pause: dac_play <= 1'b0;
            cmd_dac_resume: dac_play <= 1'b1;
            cmd_dac_props: begin
              dac_vol_select <= param_data[vol_w-1:0];
              dac_palmode    <= param_data[data_w-1];
            end
            cmd_features: featurebits <= param_data;
            cmd_region: region <= param_data[0];
            default: ;
          endcase
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd (
  input  logic                             clk,
  input  logic                             rst_n,
  // spi receiver side
  input  logic                             cmd_ready,
  input  logic                             param_ready,
  input  logic [mcu_cmd_pkg::data_w-1:0]   cmd_data,
  input  logic [mcu_cmd_pkg::data_w-1:0]   param_data,
  input  logic [mcu_cmd_pkg::cnt_w-1:0]    spi_byte_cnt,
  // memory arbiter side
  input  logic                             mcu_rq_rdy,
  input  logic [mcu_cmd_pkg::data_w-1:0]   mcu_data_in,
  // configuration
  output logic [mcu_cmd_pkg::mapper_w-1:0] mcu_mapper,
  output logic [mcu_cmd_pkg::addr_w-1:0]   rom_mask,
  output logic [mcu_cmd_pkg::addr_w-1:0]   saveram_mask,
  output logic [mcu_cmd_pkg::data_w-1:0]   featurebits,
  output logic                             region,
  output logic                             dac_play,
  output logic [mcu_cmd_pkg::vol_w-1:0]    dac_vol_select,
  output logic                             dac_palmode,
  // memory access
  output logic [mcu_cmd_pkg::addr_w-1:0]   addr_out,
  output logic                             mcu_rrq,
  output logic                             mcu_wrq,
  output logic [mcu_cmd_pkg::data_w-1:0]   mcu_data_out,
  // byte back to the microcontroller
  output logic [mcu_cmd_pkg::data_w-1:0]   spi_data_out
);
  import mcu_cmd_pkg::*;

  // end of a memory access, one cycle
  logic next_addr;

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  cmd_cfg_regs u_cmd_cfg_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .param_ready    (param_ready),
    .cmd_data       (cmd_data),
    .param_data     (param_data),
    .spi_byte_cnt   (spi_byte_cnt),
    .mcu_mapper     (mcu_mapper),
    .rom_mask       (rom_mask),
    .saveram_mask   (saveram_mask),
    .featurebits    (featurebits),
    .region         (region),
    .dac_play       (dac_play),
    .dac_vol_select (dac_vol_select),
    .dac_palmode    (dac_palmode)
  );

  ////////////////////////////////////////////////////////////
  // memory pointer and access
  ////////////////////////////////////////////////////////////

  addr_pointer u_addr_pointer (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .spi_byte_cnt (spi_byte_cnt),
    .next_addr    (next_addr),
    .addr_out     (addr_out)
  );

  mem_access u_mem_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .next_addr    (next_addr)
  );

  ////////////////////////////////////////////////////////////
  // spi return byte
  ////////////////////////////////////////////////////////////

  spi_readback u_spi_readback (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_ready    (cmd_ready),
    .param_ready  (param_ready),
    .cmd_data     (cmd_data),
    .param_data   (param_data),
    .mcu_data_in  (mcu_data_in),
    .next_addr    (next_addr),
    .spi_data_out (spi_data_out)
  );

endmodule

`default_nettype wire

//--- rtl/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_ready,
  input  logic                           param_ready,
  input  mcu_cmd_pkg::cmd_byte_t         cmd_data,
  input  logic [mcu_cmd_pkg::data_w-1:0] param_data,
  input  logic                           mcu_rq_rdy,
  output logic                           mcu_rrq,
  output logic                           mcu_wrq,
  output logic [mcu_cmd_pkg::data_w-1:0] mcu_data_out,
  output logic                           next_addr
);
  import mcu_cmd_pkg::*;

  // bit 0 is the newest sample
  logic [2:0] rdy_hist;

  ////////////////////////////////////////////////////////////
  // request pulses
  ////////////////////////////////////////////////////////////

  // read on every byte of a read command, write on parameters only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      mcu_rrq <= (cmd_ready || param_ready) && (cmd_data.f.op == op_read);
      mcu_wrq <= param_ready && (cmd_data.f.op == op_write);
    end
  end

  // write byte, held until the next write parameter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcu_data_out <= '0;
    end else if (param_ready && (cmd_data.f.op == op_write)) begin
      mcu_data_out <= param_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // ready edge
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_hist <= '0;
    end else begin
      rdy_hist <= {rdy_hist[1:0], mcu_rq_rdy};
    end
  end

  // rise after two low samples
  assign next_addr = (rdy_hist == 3'b001);

endmodule

`default_nettype wire

//--- rtl/spi_readback.sv
`timescale 1ns/1ps
`default_nettype none

module spi_readback (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           cmd_ready,
  input  logic                           param_ready,
  input  mcu_cmd_pkg::cmd_byte_t         cmd_data,
  input  logic [mcu_cmd_pkg::data_w-1:0] param_data,
  input  logic [mcu_cmd_pkg::data_w-1:0] mcu_data_in,
  input  logic                           next_addr,
  output logic [mcu_cmd_pkg::data_w-1:0] spi_data_out
);
  import mcu_cmd_pkg::*;

  logic any_strobe;
  logic read_done;

  assign any_strobe = cmd_ready || param_ready;

  // memory byte is valid when the access completes
  assign read_done = next_addr && (cmd_data.f.op == op_read);

  ////////////////////////////////////////////////////////////
  // return byte
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_data_out <= '0;
    end else if (read_done) begin
      spi_data_out <= mcu_data_in;
    end else if (any_strobe) begin
      case (cmd_data.raw)
        cmd_signature: spi_data_out <= signature;
        // echo of the last parameter
        cmd_echo: spi_data_out <= param_data;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_mcu_cmd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcu_cmd;
  import mcu_cmd_pkg::*;

  localparam int          clk_period = 10;
  localparam int          max_rows   = 24;
  localparam int          done_limit = 30;
  localparam int unsigned rand_seed  = 32'hb671bd9a;

  // what a row checks after its bytes are sent
  localparam int sel_mapper = 0;
  localparam int sel_rom    = 1;
  localparam int sel_save   = 2;
  localparam int sel_feat   = 3;
  localparam int sel_region = 4;
  localparam int sel_play   = 5;
  localparam int sel_props  = 6;
  localparam int sel_addr   = 7;
  localparam int sel_spi    = 8;
  localparam int sel_wr_inc = 9;
  localparam int sel_wr_fix = 10;
  localparam int sel_read   = 11;

  logic                clk;
  logic                rst_n;
  logic                cmd_ready;
  logic                param_ready;
  logic [data_w-1:0]   cmd_data;
  logic [data_w-1:0]   param_data;
  logic [cnt_w-1:0]    spi_byte_cnt;
  logic                mcu_rq_rdy;
  logic [data_w-1:0]   mcu_data_in;
  logic [mapper_w-1:0] mcu_mapper;
  logic [addr_w-1:0]   rom_mask;
  logic [addr_w-1:0]   saveram_mask;
  logic [data_w-1:0]   featurebits;
  logic                region;
  logic                dac_play;
  logic [vol_w-1:0]    dac_vol_select;
  logic                dac_palmode;
  logic [addr_w-1:0]   addr_out;
  logic                mcu_rrq;
  logic                mcu_wrq;
  logic [data_w-1:0]   mcu_data_out;
  logic [data_w-1:0]   spi_data_out;

  // stimulus table with the params packed first byte in the top bits
  string             t_name [0:max_rows-1];
  logic [7:0]        t_cmd  [0:max_rows-1];
  logic [31:0]       t_par  [0:max_rows-1];
  int                t_npar [0:max_rows-1];
  logic [23:0]       t_exp  [0:max_rows-1];
  logic [23:0]       t_addr [0:max_rows-1];
  int                t_sel  [0:max_rows-1];
  int                row_count  = 0;
  logic              table_done = 1'b0;

  int                err_count  = 0;
  int                fail_tests = 0;
  int                rrq_count  = 0;
  int                wrq_count  = 0;
  int                ack_count  = 0;

  // write log of the memory model
  logic [23:0]       wr_addr [0:15];
  logic [7:0]        wr_data [0:15];
  int                wr_count = 0;

  mcu_cmd u_mcu_cmd (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_ready      (cmd_ready),
    .param_ready    (param_ready),
    .cmd_data       (cmd_data),
    .param_data     (param_data),
    .spi_byte_cnt   (spi_byte_cnt),
    .mcu_rq_rdy     (mcu_rq_rdy),
    .mcu_data_in    (mcu_data_in),
    .mcu_mapper     (mcu_mapper),
    .rom_mask       (rom_mask),
    .saveram_mask   (saveram_mask),
    .featurebits    (featurebits),
    .region         (region),
    .dac_play       (dac_play),
    .dac_vol_select (dac_vol_select),
    .dac_palmode    (dac_palmode),
    .addr_out       (addr_out),
    .mcu_rrq        (mcu_rrq),
    .mcu_wrq        (mcu_wrq),
    .mcu_data_out   (mcu_data_out),
    .spi_data_out   (spi_data_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // fill pattern folds all three address bytes
  function automatic logic [7:0] fill_byte(input logic [23:0] a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5C;
  endfunction

  function automatic logic [7:0] mem_read(input logic [23:0] a);
    logic [7:0] d;
    d = fill_byte(a);
    for (int k = 0; k < wr_count; k++) begin
      if (wr_addr[k] == a) d = wr_data[k];
    end
    return d;
  endfunction

  task automatic store_byte(input logic [23:0] a, input logic [7:0] d);
    wr_addr[wr_count] = a;
    wr_data[wr_count] = d;
    wr_count++;
  endtask

  initial begin : mem_model
    int unsigned seed_var;
    int unsigned delay;
    logic [23:0] req_addr;
    logic        is_read;
    seed_var    = rand_seed;
    delay       = $urandom(seed_var);
    mcu_rq_rdy  = 1'b0;
    mcu_data_in = '0;
    forever begin
      @(negedge clk);
      if (rst_n && (mcu_rrq || mcu_wrq)) begin
        req_addr = addr_out;
        is_read  = mcu_rrq;
        if (mcu_wrq) store_byte(req_addr, mcu_data_out);
        delay = 2 + ($urandom % 5);
        repeat (delay) @(posedge clk);
        #1;
        if (is_read) mcu_data_in = mem_read(req_addr);
        mcu_rq_rdy = 1'b1;
        repeat (3) @(posedge clk);
        ack_count++;
        #1;
        mcu_rq_rdy = 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (mcu_rrq) rrq_count++;
    if (mcu_wrq) wrq_count++;
  end

  ////////////////////////////////////////////////////////////
  // table and checks
  ////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [7:0] cmd, input logic [31:0] par,
                         input int npar, input logic [23:0] exp, input logic [23:0] maddr,
                         input int sel);
    t_name[row_count] = name;
    t_cmd[row_count]  = cmd;
    t_par[row_count]  = par;
    t_npar[row_count] = npar;
    t_exp[row_count]  = exp;
    t_addr[row_count] = maddr;
    t_sel[row_count]  = sel;
    row_count++;
  endtask

  task automatic build_table();
    add_row("mapper",       8'h30, 32'hFD000000, 1, 24'h000005, 24'h0, sel_mapper);
    add_row("rom_mask",     8'h10, 32'h3FFFFE00, 3, 24'h3FFFFE, 24'h0, sel_rom);
    add_row("save_mask",    8'h20, 32'h001FFF00, 3, 24'h001FFF, 24'h0, sel_save);
    add_row("features",     8'hED, 32'hA6000000, 1, 24'h0000A6, 24'h0, sel_feat);
    add_row("region",       8'hEE, 32'h03000000, 1, 24'h000001, 24'h0, sel_region);
    // palmode from bit 7, volume from bits 2 to 0
    add_row("dac_props",    8'hEC, 32'h85000000, 1, 24'h00000D, 24'h0, sel_props);
    add_row("dac_resume",   8'hE2, 32'h00000000, 1, 24'h000001, 24'h0, sel_play);
    add_row("dac_pause",    8'hE1, 32'h00000000, 1, 24'h000000, 24'h0, sel_play);
    add_row("addr_load",    8'h00, 32'h12345600, 3, 24'h123456, 24'h0, sel_addr);
    add_row("addr_hi_only", 8'h00, 32'h7E000000, 1, 24'h7E0000, 24'h0, sel_addr);
    add_row("addr_reload",  8'h00, 32'h40210F00, 3, 24'h40210F, 24'h0, sel_addr);
    add_row("write_inc",    8'h98, 32'h3C000000, 1, 24'h00003C, 24'h40210F, sel_wr_inc);
    add_row("write_hold",   8'h90, 32'hC3000000, 1, 24'h0000C3, 24'h402110, sel_wr_fix);
    add_row("read_written", 8'h88, 32'h00000000, 0, 24'h0000C3, 24'h402110, sel_read);
    add_row("read_fill",    8'h88, 32'h00000000, 0, fill_byte(24'h402111), 24'h402111,
            sel_read);
    add_row("signature",    8'hF0, 32'h00000000, 0, 24'h0000A5, 24'h0, sel_spi);
    add_row("echo",         8'hFF, 32'h6B000000, 1, 24'h00006B, 24'h0, sel_spi);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", what, expected, actual);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      fail_tests++;
      $display("test %s: %0d error(s)", name, err_count - errs_before);
    end
  endtask

  // inputs change 1 ns after the edge
  // the count of the last byte stays on the bus
  task automatic send_command(input int i);
    logic [7:0] p;
    cmd_data     = t_cmd[i];
    spi_byte_cnt = 1;
    cmd_ready    = 1'b1;
    @(posedge clk);
    #1;
    cmd_ready = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    for (int k = 0; k < t_npar[i]; k++) begin
      p            = t_par[i][31-8*k -: 8];
      param_data   = p;
      spi_byte_cnt = k + 2;
      param_ready  = 1'b1;
      @(posedge clk);
      #1;
      param_ready = 1'b0;
      repeat (2) @(posedge clk);
      #1;
    end
  endtask

  task automatic check_row(input int i);
    string nm;
    nm = t_name[i];
    case (t_sel[i])
      sel_mapper: check_value({nm, " mcu_mapper"}, t_exp[i], mcu_mapper);
      sel_rom:    check_value({nm, " rom_mask"}, t_exp[i], rom_mask);
      sel_save:   check_value({nm, " saveram_mask"}, t_exp[i], saveram_mask);
      sel_feat:   check_value({nm, " featurebits"}, t_exp[i], featurebits);
      sel_region: check_value({nm, " region"}, t_exp[i], region);
      sel_play:   check_value({nm, " dac_play"}, t_exp[i], dac_play);
      sel_props:  check_value({nm, " dac_props"}, t_exp[i], {dac_palmode, dac_vol_select});
      sel_addr:   check_value({nm, " addr_out"}, t_exp[i], addr_out);
      sel_spi:    check_value({nm, " spi_data_out"}, t_exp[i], spi_data_out);
      sel_wr_inc, sel_wr_fix: begin
        check_value({nm, " stored byte"}, t_exp[i], mem_read(t_addr[i]));
        check_value({nm, " mcu_data_out"}, t_exp[i], mcu_data_out);
        check_value({nm, " addr_out"}, t_addr[i] + (t_sel[i] == sel_wr_inc), addr_out);
        check_value({nm, " mcu_wrq pulses"}, 1, wrq_count);
        check_value({nm, " mcu_rrq pulses"}, 0, rrq_count);
      end
      sel_read: begin
        check_value({nm, " spi_data_out"}, t_exp[i], spi_data_out);
        check_value({nm, " addr_out"}, t_addr[i] + 1, addr_out);
        check_value({nm, " mcu_rrq pulses"}, 1, rrq_count);
        check_value({nm, " mcu_wrq pulses"}, 0, wrq_count);
      end
      default: ;
    endcase
    // configuration rows issue no memory requests
    if (t_sel[i] < sel_wr_inc) begin
      check_value({nm, " mcu_rrq pulses"}, 0, rrq_count);
      check_value({nm, " mcu_wrq pulses"}, 0, wrq_count);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin : main
    int errs_before;
    int ack_goal;
    int waited;
    rst_n        = 1'b0;
    cmd_ready    = 1'b0;
    param_ready  = 1'b0;
    cmd_data     = '0;
    param_data   = '0;
    spi_byte_cnt = '0;
    build_table();
    table_done = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    check_value("reset mcu_mapper", 1, mcu_mapper);
    check_value("reset addr_out", 0, addr_out);
    check_value("reset rom_mask", 0, rom_mask);
    check_value("reset saveram_mask", 0, saveram_mask);
    check_value("reset featurebits", 0, featurebits);
    check_value("reset region", 0, region);
    check_value("reset dac_play", 0, dac_play);
    check_value("reset dac_vol_select", 0, dac_vol_select);
    check_value("reset dac_palmode", 0, dac_palmode);
    check_value("reset mcu_data_out", 0, mcu_data_out);
    check_value("reset spi_data_out", 0, spi_data_out);
    check_value("reset request pulses", 0, rrq_count + wrq_count);
    report_test("reset", 0);
    for (int i = 0; i < row_count; i++) begin
      errs_before = err_count;
      rrq_count   = 0;
      wrq_count   = 0;
      ack_goal    = ack_count + 1;
      send_command(i);
      if (t_sel[i] >= sel_wr_inc) begin
        waited = 0;
        while (ack_count < ack_goal && waited < done_limit) begin
          @(posedge clk);
          #1;
          waited++;
        end
        if (ack_count < ack_goal) begin
          err_count++;
          $display("Error in %s: memory access did not complete within %0d cycles",
                   t_name[i], done_limit);
        end
      end
      repeat (2) @(posedge clk);
      #1;
      check_row(i);
      report_test(t_name[i], errs_before);
    end
    $display("tests: %0d, failed tests: %0d, errors: %0d", row_count + 1, fail_tests,
             err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_done);
    #((row_count * 40 + 100) * clk_period);
    $display("Error: the run did not finish in time and was stopped at %0t", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
